/* hdl/stereo_pkg.sv */
package stereo_pkg;

    // image pixel, also the width of one absolute difference
    localparam int PIXEL_BITS = 8;
    typedef logic [PIXEL_BITS-1:0] pixel_t;

    // column sum holds up to 15 rows of 8-bit differences
    localparam int COLSUM_BITS = 12;
    typedef logic [COLSUM_BITS-1:0] colsum_t;

    // window SAD, wide enough for a 15x15 window
    localparam int SAD_BITS = 16;
    typedef logic [SAD_BITS-1:0] sad_t;

    localparam int DISP_BITS = 8;
    typedef logic [DISP_BITS-1:0] disp_t;

    // largest window the widths above support
    localparam int MAX_SAD = 15;

endpackage

/* hdl/stereo_absdiff.sv */
`timescale 1ns/100ps

module stereo_absdiff import stereo_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    input  logic   in_first,
    input  pixel_t in0,
    input  pixel_t in1,
    output logic   out_valid,
    output logic   out_first,
    output pixel_t out
);

    pixel_t diff;

    // subtract the smaller pixel from the larger so no sign bit is needed
    always_comb begin
        if (in0 > in1) begin
            diff = in0 - in1;
        end else begin
            diff = in1 - in0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out       <= diff;
            out_first <= in_first;  // row start marker rides with the data
        end
    end

endmodule

/* hdl/stereo_column_adder.sv */
`timescale 1ns/100ps

module stereo_column_adder import stereo_pkg::*; #(
    parameter int SAD = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic                      in_first,
    input  logic [SAD*PIXEL_BITS-1:0] in_data,
    output logic                      out_valid,
    output logic                      out_first,
    output colsum_t                   out_sum
);

    // stage one adds groups of up to four differences
    localparam int GROUPS = (SAD + 3) / 4;

    colsum_t part_next [GROUPS];
    colsum_t part_q    [GROUPS];
    colsum_t total_next;
    logic    s1_valid;
    logic    s1_first;

    always_comb begin
        int idx;
        for (int g = 0; g < GROUPS; g++) begin
            part_next[g] = '0;
            for (int i = 0; i < 4; i++) begin
                idx = g * 4 + i;
                if (idx < SAD) begin
                    part_next[g] = part_next[g] + colsum_t'(in_data[idx*PIXEL_BITS +: PIXEL_BITS]);
                end
            end
        end
    end

    always_comb begin
        total_next = '0;
        for (int g = 0; g < GROUPS; g++) begin
            total_next = total_next + part_q[g];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            part_q   <= part_next;
            s1_first <= in_first;
        end
        if (s1_valid) begin
            out_sum   <= total_next;    // full column sum
            out_first <= s1_first;
        end
    end

endmodule

/* hdl/stereo_window_accumulator.sv */
`timescale 1ns/100ps

module stereo_window_accumulator import stereo_pkg::*; #(
    parameter int SAD = 3
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  logic    in_first,
    input  colsum_t in_sum,
    output logic    out_valid,
    output sad_t    out_sad
);

    localparam int CNT_BITS = $clog2(MAX_SAD + 1);

    colsum_t             hist [SAD];   // hist[0] is the newest column
    logic [CNT_BITS-1:0] count;        // columns seen in this row, saturates at SAD
    logic [CNT_BITS-1:0] count_next;
    sad_t                total_next;

    always_comb begin
        if (in_first) begin
            count_next = CNT_BITS'(1);
            total_next = sad_t'(in_sum);
        end else begin
            if (count < CNT_BITS'(SAD)) begin
                count_next = count + CNT_BITS'(1);
            end else begin
                count_next = count;
            end
            // add the new column and drop the one leaving the window
            total_next = out_sad + sad_t'(in_sum) - sad_t'(hist[SAD-1]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (in_valid) begin
                count     <= count_next;
                out_valid <= (count_next >= CNT_BITS'(SAD));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_sad <= total_next;
            hist[0] <= in_sum;
            for (int i = 1; i < SAD; i++) begin
                if (in_first) begin
                    hist[i] <= '0;  // new row, older columns no longer count
                end else begin
                    hist[i] <= hist[i-1];
                end
            end
        end
    end

endmodule

/* hdl/stereo_match_pipe.sv */
`timescale 1ns/100ps

module stereo_match_pipe import stereo_pkg::*; #(
    parameter int SAD         = 3,
    parameter int PIPELINE_IN = 0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_right_valid,   // one cycle ahead of in_right
    input  logic                      in_valid,         // one cycle ahead of in_left
    input  logic                      in_first,
    input  logic [SAD*PIXEL_BITS-1:0] in_left,
    input  logic [SAD*PIXEL_BITS-1:0] in_right,
    output logic [SAD*PIXEL_BITS-1:0] cascade_right,
    output logic                      out_valid,
    output sad_t                      out_sad
);

    logic                      c0_right_valid;
    logic                      c0_valid;
    logic                      c1_valid;
    logic                      c1_first;
    logic [SAD*PIXEL_BITS-1:0] c1_left;
    logic [SAD*PIXEL_BITS-1:0] c1_right;
    logic                      c2_valid;
    logic                      c2_first;
    logic [SAD*PIXEL_BITS-1:0] c2_data;
    logic                      c3_valid;
    logic                      c3_first;
    colsum_t                   c3_sum;

    // valids line up with the data cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            c0_right_valid <= 1'b0;
            c0_valid       <= 1'b0;
        end else begin
            c0_right_valid <= in_right_valid;
            c0_valid       <= in_valid;
        end
    end

    // next pipe sees this right column one beat later
    always_ff @(posedge clk) begin
        if (c0_right_valid) begin
            cascade_right <= in_right;
        end
    end

    generate
        if (PIPELINE_IN == 0) begin : gen_nopipe
            assign c1_valid = c0_valid;
            assign c1_first = in_first;
            assign c1_left  = in_left;
            assign c1_right = in_right;
        end else begin : gen_pipe
            logic                      r_valid;
            logic                      r_first;
            logic [SAD*PIXEL_BITS-1:0] r_left;

            always_ff @(posedge clk) begin
                if (rst) begin
                    r_valid <= 1'b0;
                end else begin
                    r_valid <= c0_valid;
                end
            end

            always_ff @(posedge clk) begin
                r_first <= in_first;
                r_left  <= in_left;
            end

            assign c1_valid = r_valid;
            assign c1_first = r_first;
            assign c1_left  = r_left;
            assign c1_right = cascade_right;    // already holds this beat's right column
        end
    endgenerate

    // row 0 carries valid and first for the whole column
    stereo_absdiff u_absdiff0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (c1_valid),
        .in_first  (c1_first),
        .in0       (c1_left[0 +: PIXEL_BITS]),
        .in1       (c1_right[0 +: PIXEL_BITS]),
        .out_valid (c2_valid),
        .out_first (c2_first),
        .out       (c2_data[0 +: PIXEL_BITS])
    );

    for (genvar j = 1; j < SAD; j++) begin : gen_absdiff
        stereo_absdiff u_absdiff (
            .clk       (clk),
            .rst       (rst),
            .in_valid  (c1_valid),
            .in_first  (1'b0),
            .in0       (c1_left[j*PIXEL_BITS +: PIXEL_BITS]),
            .in1       (c1_right[j*PIXEL_BITS +: PIXEL_BITS]),
            .out_valid (),
            .out_first (),
            .out       (c2_data[j*PIXEL_BITS +: PIXEL_BITS])
        );
    end

    stereo_column_adder #(
        .SAD (SAD)
    ) u_column_adder (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (c2_valid),
        .in_first  (c2_first),
        .in_data   (c2_data),
        .out_valid (c3_valid),
        .out_first (c3_first),
        .out_sum   (c3_sum)
    );

    stereo_window_accumulator #(
        .SAD (SAD)
    ) u_window_accumulator (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (c3_valid),
        .in_first  (c3_first),
        .in_sum    (c3_sum),
        .out_valid (out_valid),
        .out_sad   (out_sad)
    );

endmodule

/* hdl/stereo_disparity_select.sv */
`timescale 1ns/100ps

module stereo_disparity_select import stereo_pkg::*; #(
    parameter int DISPARITIES = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_valid,
    input  logic [DISPARITIES*SAD_BITS-1:0] in_sad,    // pipe 0 in the low bits
    output logic                           out_valid,
    output sad_t                           out_sad,
    output disp_t                          out_disparity
);

    sad_t  best_sad;
    disp_t best_disp;

    // strict compare keeps the lower disparity on a tie
    always_comb begin
        sad_t cand;
        best_sad  = in_sad[0 +: SAD_BITS];
        best_disp = '0;
        for (int d = 1; d < DISPARITIES; d++) begin
            cand = in_sad[d*SAD_BITS +: SAD_BITS];
            if (cand < best_sad) begin
                best_sad  = cand;
                best_disp = disp_t'(d);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_sad       <= best_sad;
            out_disparity <= best_disp;
        end
    end

endmodule

/* hdl/stereo_match_top.sv */
`timescale 1ns/100ps

module stereo_match_top import stereo_pkg::*; #(
    parameter int SAD         = 3,
    parameter int DISPARITIES = 4,
    parameter int PIPELINE_IN = 0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_right_valid,
    input  logic                      in_valid,
    input  logic                      in_first,
    input  logic [SAD*PIXEL_BITS-1:0] in_left,
    input  logic [SAD*PIXEL_BITS-1:0] in_right,
    output logic                      out_valid,
    output sad_t                      out_sad,
    output disp_t                     out_disparity
);

    // right column chain, entry k feeds pipe k
    logic [SAD*PIXEL_BITS-1:0]       right_chain [DISPARITIES+1];
    logic [DISPARITIES-1:0]          pipe_valid;
    logic [DISPARITIES*SAD_BITS-1:0] pipe_sad;

    assign right_chain[0] = in_right;

    for (genvar k = 0; k < DISPARITIES; k++) begin : gen_pipe
        stereo_match_pipe #(
            .SAD         (SAD),
            .PIPELINE_IN (PIPELINE_IN)
        ) u_pipe (
            .clk            (clk),
            .rst            (rst),
            .in_right_valid (in_right_valid),
            .in_valid       (in_valid),
            .in_first       (in_first),
            .in_left        (in_left),
            .in_right       (right_chain[k]),
            .cascade_right  (right_chain[k+1]),
            .out_valid      (pipe_valid[k]),
            .out_sad        (pipe_sad[k*SAD_BITS +: SAD_BITS])
        );
    end

    // pipes run in lockstep so pipe 0 times the selector
    stereo_disparity_select #(
        .DISPARITIES (DISPARITIES)
    ) u_select (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (pipe_valid[0]),
        .in_sad        (pipe_sad),
        .out_valid     (out_valid),
        .out_sad       (out_sad),
        .out_disparity (out_disparity)
    );

endmodule

/* tests/stereo_match_tb.sv */
`timescale 1ns/100ps

module stereo_match_tb import stereo_pkg::*; ();

    localparam int SAD         = 3;
    localparam int DISPARITIES = 4;
    localparam int COL_BITS    = SAD * PIXEL_BITS;
    localparam int TIMEOUT     = 200;   // cycles allowed for the last outputs

    logic                clk;
    logic                rst;
    logic                in_right_valid;
    logic                in_valid;
    logic                in_first;
    logic [COL_BITS-1:0] in_left;
    logic [COL_BITS-1:0] in_right;
    logic                out_valid;
    sad_t                out_sad;
    disp_t               out_disparity;

    // input beats and expected selector outputs in file order
    logic                beat_first [$];
    logic [COL_BITS-1:0] beat_left  [$];
    logic [COL_BITS-1:0] beat_right [$];
    disp_t               exp_disp   [$];
    sad_t                exp_sad    [$];
    logic [31:0]         lcg_state;

    stereo_match_top #(
        .SAD         (SAD),
        .DISPARITIES (DISPARITIES),
        .PIPELINE_IN (0)
    ) dut0 (
        .clk            (clk),
        .rst            (rst),
        .in_right_valid (in_right_valid),
        .in_valid       (in_valid),
        .in_first       (in_first),
        .in_left        (in_left),
        .in_right       (in_right),
        .out_valid      (out_valid),
        .out_sad        (out_sad),
        .out_disparity  (out_disparity)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // 0 to 3 idle cycles before the next beat
    function automatic int idle_cycles();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[17:16]);
    endfunction

    task automatic abort_run(input string why);
        $display("error at %0t: %s", $time, why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, want);
            abort_run("wrong output value");
        end
    endtask

    task automatic load_stimulus();
        int                  fd;
        int                  code;
        int                  f;
        int                  d;
        int                  s;
        logic [63:0]         word;
        logic [8*128-1:0]    rest;
        logic [COL_BITS-1:0] l;
        logic [COL_BITS-1:0] r;
        fd = $fopen("tests/stereo_match_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tests/stereo_match_stimulus.txt");
        end
        while ($fscanf(fd, "%s", word) == 1) begin
            if (word == "#") begin
                code = $fgets(rest, fd);    // rest of a comment line
            end else if (word == "beat") begin
                code = $fscanf(fd, "%d %h %h", f, l, r);
                if (code != 3) begin
                    abort_run("incomplete beat line in stimulus file");
                end
                beat_first.push_back(f[0]);
                beat_left.push_back(l);
                beat_right.push_back(r);
            end else if (word == "expect") begin
                code = $fscanf(fd, "%d %d", d, s);
                if (code != 2) begin
                    abort_run("incomplete expect line in stimulus file");
                end
                exp_disp.push_back(disp_t'(d));
                exp_sad.push_back(sad_t'(s));
            end else begin
                abort_run("unknown line type in stimulus file");
            end
        end
        $fclose(fd);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : monitor
        disp_t want_disp;
        sad_t  want_sad;
        if (out_valid === 1'b1) begin
            if (exp_disp.size() == 0) begin
                abort_run("out_valid high while no expected result is pending");
            end else begin
                want_disp = exp_disp.pop_front();
                want_sad  = exp_sad.pop_front();
                check_value("out_disparity", out_disparity, want_disp);
                check_value("out_sad", out_sad, want_sad);
            end
        end
    end

    initial begin
        int i;
        int pend;
        int idle;
        int wait_cnt;
        lcg_state      = 32'd25391;
        rst            = 1'b1;
        in_right_valid = 1'b0;
        in_valid       = 1'b0;
        in_first       = 1'b0;
        in_left        = '0;
        in_right       = '0;
        load_stimulus();
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        i    = 0;
        pend = -1;  // beat whose data goes out on the next edge
        idle = idle_cycles();
        while (i < beat_first.size() || pend >= 0) begin
            @(posedge clk);
            if (pend >= 0) begin
                in_first <= beat_first[pend];
                in_left  <= beat_left[pend];
                in_right <= beat_right[pend];
                pend = -1;
            end
            if (i < beat_first.size() && idle == 0) begin
                in_valid       <= 1'b1;     // data follows one cycle later
                in_right_valid <= 1'b1;
                pend = i;
                i++;
                idle = idle_cycles();
            end else begin
                in_valid       <= 1'b0;
                in_right_valid <= 1'b0;
                if (idle > 0) begin
                    idle--;
                end
            end
        end

        wait_cnt = 0;
        while (exp_disp.size() > 0 && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        repeat (10) @(posedge clk);     // catch any extra output
        if (exp_disp.size() != 0) begin
            $display("timeout: %0d expected outputs still missing", exp_disp.size());
            abort_run("outputs did not arrive in time");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* project.f */
hdl/stereo_pkg.sv
hdl/stereo_absdiff.sv
hdl/stereo_column_adder.sv
hdl/stereo_window_accumulator.sv
hdl/stereo_match_pipe.sv
hdl/stereo_disparity_select.sv
hdl/stereo_match_top.sv
tests/stereo_match_tb.sv

/* tests/stereo_match_stimulus.txt */
# beat <first> <left> <right> : columns in hex, row 0 in the low byte
# expect <disparity> <sad> : selector outputs in order, decimal
# two short rows fill the right cascade and give no output
beat 1 000000 000000
beat 0 000000 000000
beat 1 000000 0a0a0a
beat 0 000000 282828
# right image is the left image shifted by 2 columns
beat 1 0a0a0a 141414
beat 0 282828 464646
beat 0 141414 1e1e1e
beat 0 464646 3c3c3c
beat 0 1e1e1e 0a0a0a
beat 0 3c3c3c 323232
beat 0 0a0a0a 505050
beat 0 323232 000000
expect 2 0
expect 2 0
expect 2 0
expect 2 0
expect 2 0
expect 2 0
# repeating texture where disparities 1 and 3 tie
beat 1 000000 505050
beat 0 505050 000000
beat 0 000000 505050
beat 0 505050 000000
beat 0 000000 505050
beat 0 505050 000000
expect 1 0
expect 1 0
expect 1 0
expect 1 0
# noisy right data with distinct rows per column
beat 1 1e140a 1c190c
beat 0 3c3228 3d3921
beat 0 5a5046 63464b
beat 0 141414 0f2800
beat 0 3c3c1e 0a375a
beat 0 5f4846 5f3223
beat 0 0e2902 820ac8
expect 0 48
expect 0 84
expect 0 184
expect 3 39
expect 3 22
